// ==== logic/wexIsaPkg.sv ====
// WEX instruction format definitions
`default_nettype none

package wexIsaPkg;

	localparam int slotBits = 32;
	localparam int gprBits = 6;
	localparam int immBits = 33;
	localparam int shortImmBits = 6;
	localparam int jumboPayloadBits = 24;

	typedef logic [2*slotBits-1:0] bundleWord_t; // Slot 1 in the upper half
	typedef logic [slotBits-1:0] slotWord_t;
	typedef logic [gprBits-1:0] gprIdx_t;
	typedef logic [immBits-1:0] immVal_t;
	typedef logic [shortImmBits-1:0] shortImm_t;
	typedef logic [jumboPayloadBits-1:0] jumboBits_t;

	localparam gprIdx_t gprZero = '1; // Zero register, also marks unused

	typedef enum logic [3:0]
	{
		opNop = 4'd0,
		opAdd,
		opSub,
		opAnd,
		opOr,
		opXor,
		opShad,
		opCmpEq,
		opCmpGt,
		opMov,
		opLdq,
		opStq,
		opAddi,
		opMovi,
		opSpare, // Decodes as opInvop
		opInvop
	} uOpcode_t;

	// Prefix fields, positions within one slot
	localparam int prefixHi = 15;
	localparam int prefixLo = 12;
	localparam logic [3:0] prefixPredicated = 4'hE;
	localparam logic [3:0] prefixUncond = 4'hF;
	localparam int prefixDfBit = 10; // Pred-false or WEX
	localparam int prefixWexHiBit = 11;
	localparam int prefixWexLoBit = 9;
	localparam int jumboHi = 15;
	localparam int jumboLo = 9;
	localparam logic [6:0] jumboMark = 7'h7F;
	localparam int jumboHeadHi = 7; // Payload is bits 7:0 then 31:16
	localparam int jumboTailLo = 16;

	// Operation fields
	localparam int opcodeHi = 31;
	localparam int opcodeLo = 28;
	localparam int rnHi = 27;
	localparam int rnLo = 22;
	localparam int rmHi = 21;
	localparam int rmLo = 16;
	localparam int roHi = 5;
	localparam int roLo = 0;
	localparam int widthHi = 7;
	localparam int widthLo = 6;
	localparam logic [1:0] widthWide = 2'b11;

	function automatic immVal_t sextShort(input shortImm_t value);
		return {{(immBits - shortImmBits){value[shortImmBits-1]}}, value};
	endfunction

endpackage

`default_nettype wire

// ==== logic/wexDecPkg.sv ====
// WEX decode stage types
`default_nettype none

package wexDecPkg;

	typedef enum logic [1:0]
	{
		predAlways = 2'd0,
		predIfTrue,
		predIfFalse
	} predMode_t;

	typedef struct packed
	{
		logic is32; // E or F prefix
		predMode_t predMode;
		logic wexFlag;
		logic isJumbo; // Slot 0 only
	} slotClass_t;

	typedef struct packed
	{
		wexIsaPkg::uOpcode_t opcode;
		wexIsaPkg::gprIdx_t regN;
		wexIsaPkg::gprIdx_t regM;
		wexIsaPkg::gprIdx_t regO;
		wexIsaPkg::shortImm_t shortImm; // Zero for register ops
		logic isImm;
		logic isWide;
	} slotFields_t;

	typedef struct packed
	{
		wexIsaPkg::uOpcode_t opcode;
		predMode_t predMode;
		wexIsaPkg::gprIdx_t regN;
		wexIsaPkg::gprIdx_t regM;
		wexIsaPkg::gprIdx_t regO;
		wexIsaPkg::immVal_t imm;
	} laneUop_t;

	localparam laneUop_t nopUop = '{
		opcode: wexIsaPkg::opNop,
		predMode: predAlways,
		regN: wexIsaPkg::gprZero,
		regM: wexIsaPkg::gprZero,
		regO: wexIsaPkg::gprZero,
		imm: '0
	};

	localparam laneUop_t invUop = '{
		opcode: wexIsaPkg::opInvop,
		predMode: predAlways,
		regN: wexIsaPkg::gprZero,
		regM: wexIsaPkg::gprZero,
		regO: wexIsaPkg::gprZero,
		imm: '0
	};

endpackage

`default_nettype wire

// ==== logic/bundleClassifier.sv ====
// Bundle prefix classifier
`default_nettype none

module bundleClassifier
(
	input wire wexIsaPkg::bundleWord_t bundleWord,
	input wire logic wexEnable,
	output wexDecPkg::slotClass_t slotClass0,
	output wexDecPkg::slotClass_t slotClass1,
	output wexIsaPkg::jumboBits_t jumboBits
);

	wexIsaPkg::slotWord_t slot0;
	wexIsaPkg::slotWord_t slot1;

	// Same prefix rules for either slot
	function automatic wexDecPkg::slotClass_t classifySlot(
		input wexIsaPkg::slotWord_t slot,
		input logic wexEn
	);
		wexDecPkg::slotClass_t cls;
		logic [3:0] nibble;
		cls = '0;
		nibble = slot[wexIsaPkg::prefixHi:wexIsaPkg::prefixLo];
		if (nibble == wexIsaPkg::prefixUncond)
		begin
			cls.is32 = 1'b1; // Unconditional
			cls.predMode = wexDecPkg::predAlways;
			cls.wexFlag = wexEn && slot[wexIsaPkg::prefixDfBit];
		end
		else if (nibble == wexIsaPkg::prefixPredicated)
		begin
			cls.is32 = 1'b1;
			cls.predMode = slot[wexIsaPkg::prefixDfBit] ?
				wexDecPkg::predIfFalse : wexDecPkg::predIfTrue;
			// Predicated WEX form
			cls.wexFlag = wexEn && slot[wexIsaPkg::prefixWexHiBit] &&
				slot[wexIsaPkg::prefixWexLoBit];
		end
		return cls;
	endfunction

	assign slot0 = bundleWord[wexIsaPkg::slotBits-1:0];
	assign slot1 = bundleWord[2*wexIsaPkg::slotBits-1:wexIsaPkg::slotBits];

	always_comb
	begin
		slotClass0 = classifySlot(slot0, wexEnable);
		slotClass0.isJumbo =
			(slot0[wexIsaPkg::jumboHi:wexIsaPkg::jumboLo] == wexIsaPkg::jumboMark);
		slotClass1 = classifySlot(slot1, wexEnable); // Never a jumbo prefix
	end

	// Payload used only when slot 0 is a jumbo prefix
	assign jumboBits = {
		slot0[wexIsaPkg::jumboHeadHi:0],
		slot0[wexIsaPkg::slotBits-1:wexIsaPkg::jumboTailLo]
	};

endmodule

`default_nettype wire

// ==== logic/opFieldDecoder.sv ====
// Slot field decoder
`default_nettype none

module opFieldDecoder
(
	input wire wexIsaPkg::slotWord_t slotWord,
	output wexDecPkg::slotFields_t slotFields
);

	wexIsaPkg::uOpcode_t opcode;
	logic isImm;
	logic wideForm;

	always_comb
	begin
		opcode = wexIsaPkg::uOpcode_t'(slotWord[wexIsaPkg::opcodeHi:wexIsaPkg::opcodeLo]);
		if (opcode == wexIsaPkg::opSpare)
		begin
			opcode = wexIsaPkg::opInvop; // Spare encoding is not an op
		end
	end

	assign isImm = opcode inside {
		wexIsaPkg::opAddi,
		wexIsaPkg::opMovi,
		wexIsaPkg::opLdq,
		wexIsaPkg::opStq
	};

	assign wideForm =
		(slotWord[wexIsaPkg::widthHi:wexIsaPkg::widthLo] == wexIsaPkg::widthWide);

	always_comb
	begin
		slotFields.opcode = opcode;
		slotFields.regN = slotWord[wexIsaPkg::rnHi:wexIsaPkg::rnLo];
		slotFields.regM = slotWord[wexIsaPkg::rmHi:wexIsaPkg::rmLo];
		slotFields.isImm = isImm;
		slotFields.isWide = wideForm && !isImm; // Immediate forms are never wide
		if (isImm)
		begin
			// Ro field carries the short immediate
			slotFields.regO = wexIsaPkg::gprZero;
			slotFields.shortImm = slotWord[wexIsaPkg::roHi:wexIsaPkg::roLo];
		end
		else
		begin
			slotFields.regO = slotWord[wexIsaPkg::roHi:wexIsaPkg::roLo];
			slotFields.shortImm = '0;
		end
	end

endmodule

`default_nettype wire

// ==== logic/dualLanePairer.sv ====
// Register pairing for wide ops
`default_nettype none

module dualLanePairer
(
	input wire wexDecPkg::slotFields_t wideFields,
	output wexDecPkg::laneUop_t pairLo,
	output wexDecPkg::laneUop_t pairHi
);

	logic swapLanes;

	// Even/odd pair index, swap bit picks which half lands in lane A
	function automatic wexIsaPkg::gprIdx_t pairReg(
		input wexIsaPkg::gprIdx_t r,
		input logic swap
	);
		return {r[0], r[4:1], swap};
	endfunction

	assign swapLanes = wideFields.opcode inside {
		wexIsaPkg::opCmpEq,
		wexIsaPkg::opCmpGt,
		wexIsaPkg::opShad
	};

	always_comb
	begin
		pairLo.opcode = wideFields.opcode;
		pairLo.predMode = wexDecPkg::predAlways; // Router applies slot predicate
		pairLo.regN = pairReg(wideFields.regN, swapLanes);
		pairLo.regM = pairReg(wideFields.regM, swapLanes);
		pairLo.regO = pairReg(wideFields.regO, swapLanes);
		pairLo.imm = wexIsaPkg::sextShort(wideFields.shortImm);

		pairHi = pairLo;
		pairHi.regN = pairLo.regN ^ wexIsaPkg::gprIdx_t'(1); // Other half of the pair
		pairHi.regM = pairLo.regM ^ wexIsaPkg::gprIdx_t'(1);
		pairHi.regO = pairLo.regO ^ wexIsaPkg::gprIdx_t'(1);
	end

endmodule

`default_nettype wire

// ==== logic/laneRouter.sv ====
// Lane assignment and output register
`default_nettype none

module laneRouter
(
	input wire logic clock,
	input wire logic reset,
	input wire wexDecPkg::slotClass_t slotClass0,
	input wire wexDecPkg::slotClass_t slotClass1,
	input wire wexDecPkg::slotFields_t fields0,
	input wire wexDecPkg::slotFields_t fields1,
	input wire wexIsaPkg::jumboBits_t jumboBits,
	input wire wexDecPkg::laneUop_t pairLo,
	input wire wexDecPkg::laneUop_t pairHi,
	output wexDecPkg::slotFields_t scalarFields,
	output wexDecPkg::laneUop_t laneA,
	output wexDecPkg::laneUop_t laneB
);

	localparam int jumboExtBits =
		wexIsaPkg::immBits - wexIsaPkg::jumboPayloadBits - wexIsaPkg::shortImmBits;

	wexDecPkg::laneUop_t nextA;
	wexDecPkg::laneUop_t nextB;

	function automatic wexDecPkg::laneUop_t slotUop(
		input wexDecPkg::slotFields_t f,
		input wexDecPkg::predMode_t pred
	);
		wexDecPkg::laneUop_t u;
		u.opcode = f.opcode;
		u.predMode = pred;
		u.regN = f.regN;
		u.regM = f.regM;
		u.regO = f.regO;
		u.imm = f.isImm ? wexIsaPkg::sextShort(f.shortImm) : '0;
		return u;
	endfunction

	// Jumbo form runs slot 1 as the scalar op
	assign scalarFields = slotClass0.isJumbo ? fields1 : fields0;

	always_comb
	begin
		nextA = wexDecPkg::nopUop;
		nextB = wexDecPkg::nopUop;
		if (slotClass0.isJumbo)
		begin
			nextA = slotUop(scalarFields, slotClass1.predMode);
			if (scalarFields.isImm)
			begin
				nextA.imm = {
					{jumboExtBits{jumboBits[wexIsaPkg::jumboPayloadBits-1]}},
					jumboBits,
					scalarFields.shortImm
				};
			end
		end
		else if (slotClass0.wexFlag && slotClass1.wexFlag)
		begin
			nextA = wexDecPkg::invUop; // No third lane for a WEX3 bundle
		end
		else if (slotClass0.wexFlag)
		begin
			// WEX pair, the later slot goes to lane A
			nextA = slotUop(fields1, slotClass1.predMode);
			nextB = slotUop(fields0, slotClass0.predMode);
		end
		else if (!slotClass0.is32)
		begin
			nextA = wexDecPkg::invUop; // No 16-bit decoder
		end
		else if (scalarFields.isWide)
		begin
			nextA = pairLo;
			nextA.predMode = slotClass0.predMode;
			nextB = pairHi;
			nextB.predMode = slotClass0.predMode;
		end
		else
		begin
			nextA = slotUop(scalarFields, slotClass0.predMode);
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			laneA <= wexDecPkg::nopUop;
			laneB <= wexDecPkg::nopUop;
		end
		else
		begin
			laneA <= nextA;
			laneB <= nextB;
		end
	end

endmodule

`default_nettype wire

// ==== logic/wexDecoder.sv ====
// Two-wide WEX lane decoder
`default_nettype none

module wexDecoder
(
	input wire logic clock,
	input wire logic reset,
	input wire wexIsaPkg::bundleWord_t bundleWord,
	input wire logic wexEnable,
	output wexDecPkg::laneUop_t laneA,
	output wexDecPkg::laneUop_t laneB
);

	wexDecPkg::slotClass_t slotClass0;
	wexDecPkg::slotClass_t slotClass1;
	wexIsaPkg::jumboBits_t jumboBits;
	wexDecPkg::slotFields_t fields0;
	wexDecPkg::slotFields_t fields1;
	wexDecPkg::slotFields_t scalarFields;
	wexDecPkg::laneUop_t pairLo;
	wexDecPkg::laneUop_t pairHi;

	bundleClassifier i_bundleClassifier
	(
		.bundleWord(bundleWord),
		.wexEnable(wexEnable),
		.slotClass0(slotClass0),
		.slotClass1(slotClass1),
		.jumboBits(jumboBits)
	);

	opFieldDecoder i_opFieldDecoder0
	(
		.slotWord(bundleWord[wexIsaPkg::slotBits-1:0]),
		.slotFields(fields0)
	);

	opFieldDecoder i_opFieldDecoder1
	(
		.slotWord(bundleWord[2*wexIsaPkg::slotBits-1:wexIsaPkg::slotBits]),
		.slotFields(fields1)
	);

	dualLanePairer i_dualLanePairer
	(
		.wideFields(scalarFields),
		.pairLo(pairLo),
		.pairHi(pairHi)
	);

	laneRouter i_laneRouter
	(
		.clock(clock),
		.reset(reset),
		.slotClass0(slotClass0),
		.slotClass1(slotClass1),
		.fields0(fields0),
		.fields1(fields1),
		.jumboBits(jumboBits),
		.pairLo(pairLo),
		.pairHi(pairHi),
		.scalarFields(scalarFields),
		.laneA(laneA),
		.laneB(laneB)
	);

endmodule

`default_nettype wire

// ==== include/wexDecoderModel.svh ====
// Expected lane model
`ifndef WEX_DECODER_MODEL_SVH
`define WEX_DECODER_MODEL_SVH

function automatic wexDecPkg::predMode_t slotPred(input wexIsaPkg::slotWord_t w);
	if (w[15:12] == 4'hE)
	begin
		return w[10] ? wexDecPkg::predIfFalse : wexDecPkg::predIfTrue;
	end
	return wexDecPkg::predAlways;
endfunction

function automatic logic slotWex(input wexIsaPkg::slotWord_t w, input logic en);
	return en && (((w[15:12] == 4'hF) && w[10]) || ((w[15:12] == 4'hE) && w[11] && w[9]));
endfunction

function automatic logic isImmOp(input logic [3:0] op);
	return op inside {4'd10, 4'd11, 4'd12, 4'd13}; // LDQ STQ ADDI MOVI
endfunction

// Idle lane with the zero register in every field
function automatic wexDecPkg::laneUop_t nopLane();
	wexDecPkg::laneUop_t u;
	u.opcode = wexIsaPkg::uOpcode_t'(4'd0);
	u.predMode = wexDecPkg::predAlways;
	u.regN = 6'h3F;
	u.regM = 6'h3F;
	u.regO = 6'h3F;
	u.imm = 33'd0;
	return u;
endfunction

function automatic wexDecPkg::laneUop_t invLane();
	wexDecPkg::laneUop_t u;
	u = nopLane();
	u.opcode = wexIsaPkg::uOpcode_t'(4'd15);
	return u;
endfunction

// Plain decode of one slot
function automatic wexDecPkg::laneUop_t decodeSlot(
	input wexIsaPkg::slotWord_t w,
	input wexDecPkg::predMode_t pred
);
	wexDecPkg::laneUop_t u;
	logic [3:0] op;
	op = w[31:28];
	if (op == 4'd14)
	begin
		op = 4'd15;
	end
	u.opcode = wexIsaPkg::uOpcode_t'(op);
	u.predMode = pred;
	u.regN = w[27:22];
	u.regM = w[21:16];
	u.regO = isImmOp(op) ? 6'h3F : w[5:0];
	u.imm = isImmOp(op) ? {{27{w[5]}}, w[5:0]} : 33'd0;
	return u;
endfunction

function automatic void expectedLanes(
	input wexIsaPkg::bundleWord_t bw,
	input logic wexEnable,
	output wexDecPkg::laneUop_t expA,
	output wexDecPkg::laneUop_t expB
);
	logic [31:0] s0;
	logic [31:0] s1;
	logic [23:0] jb;
	logic swap;
	wexDecPkg::laneUop_t lo;
	s0 = bw[31:0];
	s1 = bw[63:32];
	jb = {s0[7:0], s0[31:16]};
	expA = nopLane();
	expB = nopLane();
	lo = decodeSlot(s0, slotPred(s0));
	if (s0[15:9] == 7'h7F)
	begin
		expA = decodeSlot(s1, slotPred(s1));
		if (isImmOp(expA.opcode))
		begin
			expA.imm = {{3{jb[23]}}, jb, s1[5:0]};
		end
	end
	else if (slotWex(s0, wexEnable) && slotWex(s1, wexEnable))
	begin
		expA = invLane();
	end
	else if (slotWex(s0, wexEnable))
	begin
		expA = decodeSlot(s1, slotPred(s1));
		expB = lo;
	end
	else if (s0[15:12] != 4'hE && s0[15:12] != 4'hF)
	begin
		expA = invLane();
	end
	else if (s0[7:6] == 2'b11 && !isImmOp(lo.opcode))
	begin
		swap = lo.opcode inside {4'd6, 4'd7, 4'd8}; // SHAD CMPEQ CMPGT
		lo.regN = {lo.regN[0], lo.regN[4:1], swap};
		lo.regM = {lo.regM[0], lo.regM[4:1], swap};
		lo.regO = {lo.regO[0], lo.regO[4:1], swap};
		expA = lo;
		expB = lo;
		expB.regN = lo.regN ^ 6'd1;
		expB.regM = lo.regM ^ 6'd1;
		expB.regO = lo.regO ^ 6'd1;
	end
	else
	begin
		expA = lo;
	end
endfunction

`endif

// ==== sim/wexDecoderTb.sv ====
// WEX decoder testbench
`default_nettype none

module wexDecoderTb;

	localparam int resetCycles = 3;
	localparam int resetTimeout = 10;
	localparam int bundleCount = 2000;

	logic clock;
	logic reset;
	wexIsaPkg::bundleWord_t bundleWord;
	logic wexEnable;
	wexDecPkg::laneUop_t laneA;
	wexDecPkg::laneUop_t laneB;

	`include "wexDecoderModel.svh"

	wexDecoder i_wexDecoder
	(
		.clock(clock),
		.reset(reset),
		.bundleWord(bundleWord),
		.wexEnable(wexEnable),
		.laneA(laneA),
		.laneB(laneB)
	);

	always #4 clock = ~clock; // Period 8

	function automatic logic [3:0] randNibble(input int unsigned base, input int unsigned span);
		int unsigned r;
		r = base + $urandom() % span;
		return r[3:0];
	endfunction

	// 32-bit slot without WEX flag and without jumbo mark
	function automatic logic [31:0] plainSlot(input logic [31:0] w);
		logic [31:0] r;
		r = w;
		if (w[12])
		begin
			r[15:12] = 4'hF;
			r[10] = 1'b0;
		end
		else
		begin
			r[15:12] = 4'hE; // Bit 10 picks IFTRUE or IFFALSE
			r[9] = 1'b0;
		end
		return r;
	endfunction

	task automatic makeBundle(output wexIsaPkg::bundleWord_t bw, output logic en);
		logic [31:0] s0;
		logic [31:0] s1;
		int unsigned category;
		s0 = $urandom();
		s1 = $urandom();
		en = ($urandom() % 2) == 0;
		category = $urandom() % 6;
		case (category)
			0:
			begin
				s0 = plainSlot(s0);
				s0[7] = 1'b0; // Scalar and never wide
			end
			1:
			begin
				s0 = plainSlot(s0);
				s0[15:12] = 4'hF;
				s0[10] = 1'b1; // WEX pair
				s0[9] = 1'b0;
				s1 = plainSlot(s1);
				en = ($urandom() % 4) != 0; // Mostly enabled
			end
			2:
			begin
				s0[15:12] = 4'hF;
				s0[10] = 1'b1;
				s0[9] = 1'b0;
				s1[15:12] = 4'hE; // Predicated WEX form in slot 1
				s1[11] = 1'b1;
				s1[9] = 1'b1;
				en = 1'b1;
			end
			3:
			begin
				s0[15:9] = 7'h7F; // Jumbo prefix
				s1 = plainSlot(s1);
				if (($urandom() % 4) != 0)
				begin
					s1[31:28] = randNibble(10, 4); // LDQ STQ ADDI MOVI
				end
			end
			4:
			begin
				s0 = plainSlot(s0);
				s0[7:6] = 2'b11;
				s0[31:28] = randNibble(0, 10); // Register ops only
			end
			default:
			begin
				s0[15:12] = randNibble(0, 14); // No 32-bit prefix
			end
		endcase
		bw = {s1, s0};
	endtask

	task automatic checkLane(
		input string name,
		input wexDecPkg::laneUop_t got,
		input wexDecPkg::laneUop_t exp
	);
		if (got !== exp)
		begin
			$display("ERR %s got=%h expected=%h", name, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "Lane mismatch");
		end
	endtask

	initial
	begin
		int cycles;
		int n;
		wexDecPkg::laneUop_t expA;
		wexDecPkg::laneUop_t expB;
		void'($urandom(39289));
		clock = 1'b0;
		reset = 1'b1;
		bundleWord = '0;
		wexEnable = 1'b0;
		cycles = 0;
		while (!((laneA === nopLane()) && (laneB === nopLane())) &&
			(cycles < resetTimeout))
		begin
			@(negedge clock);
			cycles++;
		end
		if ((laneA !== nopLane()) || (laneB !== nopLane()))
		begin
			$display("Both lanes did not load the NOP micro-op while reset was held");
			$display("TESTS FAILED");
			$fatal(1, "Reset wait timed out");
		end
		while (cycles < resetCycles)
		begin
			@(negedge clock);
			cycles++;
			checkLane("laneA", laneA, nopLane());
			checkLane("laneB", laneB, nopLane());
		end
		reset = 1'b0;
		makeBundle(bundleWord, wexEnable);
		for (n = 0; n < bundleCount; n++)
		begin
			@(negedge clock);
			expectedLanes(bundleWord, wexEnable, expA, expB); // Bundle of the previous edge
			checkLane("laneA", laneA, expA);
			checkLane("laneB", laneB, expB);
			makeBundle(bundleWord, wexEnable);
		end
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== wexDecoder.f ====
+incdir+include
logic/wexIsaPkg.sv
logic/wexDecPkg.sv
logic/bundleClassifier.sv
logic/opFieldDecoder.sv
logic/dualLanePairer.sv
logic/laneRouter.sv
logic/wexDecoder.sv
sim/wexDecoderTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS = --binary --timing -j 0
LINTFLAGS = --lint-only --timing
TOP = wexDecoderTb
RTL_TOP = wexDecoder
FILELIST = wexDecoder.f
OBJDIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
